// File: src/ooo_cfg.svh
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

`define OOO_XLEN       32
`define OOO_ARCH_REGS  32
`define OOO_ROB_DEPTH  8   // also rs depth and issue credits

// one spare physical register per rob slot
`define OOO_PHYS_REGS  (`OOO_ARCH_REGS + `OOO_ROB_DEPTH)

`define OOO_MUL_CYCLES 32  // shift-add iterations

`endif

// File: src/ooo_pkg.sv
`include "ooo_cfg.svh"

package ooo_pkg;

    typedef logic [`OOO_XLEN-1:0]                xdata_t;
    typedef logic [$clog2(`OOO_ARCH_REGS)-1:0]   arch_reg_t;
    typedef logic [$clog2(`OOO_PHYS_REGS)-1:0]   phys_tag_t;
    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0]   rob_idx_t;
    typedef logic [11:0]                         imm_t;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_addi,
        op_mul
    } alu_op_t;

    typedef enum logic [1:0] {
        mul_idle,
        mul_busy,
        mul_done
    } mul_state_t;

endpackage

// File: src/rename_unit.sv
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module rename_unit import ooo_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      issue_valid,
    input  alu_op_t   issue_op,
    input  arch_reg_t issue_rd,
    input  arch_reg_t issue_rs1,
    input  arch_reg_t issue_rs2,
    input  imm_t      issue_imm,
    input  logic      free_valid,
    input  phys_tag_t free_tag,
    output phys_tag_t src1_tag,
    output phys_tag_t src2_tag,
    output logic      dispatch_alu,
    output logic      dispatch_mul,
    output alu_op_t   dispatch_op,
    output xdata_t    dispatch_imm,
    output phys_tag_t dest_tag,
    output phys_tag_t old_tag,
    output arch_reg_t dispatch_rd
);
    phys_tag_t map_q [`OOO_ARCH_REGS];
    phys_tag_t fl_q [`OOO_ROB_DEPTH];   // circular free list
    rob_idx_t  fl_head;
    rob_idx_t  fl_tail;
    logic      alloc;

    assign alloc = issue_valid && (issue_rd != '0);

    assign src1_tag = map_q[issue_rs1];
    assign src2_tag = map_q[issue_rs2];
    assign old_tag  = map_q[issue_rd];
    assign dest_tag = (issue_rd == '0) ? '0 : fl_q[fl_head];  // x0 results go to tag 0

    assign dispatch_rd  = issue_rd;
    assign dispatch_op  = issue_op;
    assign dispatch_imm = {{(`OOO_XLEN - $bits(imm_t)){issue_imm[$bits(imm_t)-1]}}, issue_imm};
    assign dispatch_mul = issue_valid && (issue_op == op_mul);
    assign dispatch_alu = issue_valid && (issue_op != op_mul);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `OOO_ARCH_REGS; i++) begin
                map_q[i] <= phys_tag_t'(i);
            end
            for (int i = 0; i < `OOO_ROB_DEPTH; i++) begin
                fl_q[i] <= phys_tag_t'(`OOO_ARCH_REGS + i);
            end
            fl_head <= '0;
            fl_tail <= '0;
        end else begin
            if (alloc) begin
                map_q[issue_rd] <= fl_q[fl_head];
                fl_head         <= fl_head + 1'b1;
            end
            if (free_valid) begin
                fl_q[fl_tail] <= free_tag;  // old mapping back from commit
                fl_tail       <= fl_tail + 1'b1;
            end
        end
    end

endmodule

// File: src/phys_regfile.sv
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module phys_regfile import ooo_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  phys_tag_t src1_tag,
    input  phys_tag_t src2_tag,
    input  phys_tag_t dest_tag,
    input  logic      dispatch_valid,
    input  logic      cdb_valid,
    input  phys_tag_t cdb_tag,
    input  xdata_t    cdb_data,
    output xdata_t    src1_data,
    output xdata_t    src2_data,
    output logic      src1_ready,
    output logic      src2_ready
);
    xdata_t                   regs_q [`OOO_PHYS_REGS];
    logic [`OOO_PHYS_REGS-1:0] rdy_q;
    logic                     hit1;
    logic                     hit2;

    // bus bypass never hits tag 0 since it must stay zero
    assign hit1 = cdb_valid && (cdb_tag == src1_tag) && (src1_tag != '0);
    assign hit2 = cdb_valid && (cdb_tag == src2_tag) && (src2_tag != '0);

    assign src1_data  = hit1 ? cdb_data : regs_q[src1_tag];
    assign src2_data  = hit2 ? cdb_data : regs_q[src2_tag];
    assign src1_ready = hit1 || rdy_q[src1_tag];
    assign src2_ready = hit2 || rdy_q[src2_tag];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `OOO_PHYS_REGS; i++) begin
                regs_q[i] <= '0;
            end
            rdy_q <= '1;
        end else begin
            if (cdb_valid && (cdb_tag != '0)) begin
                regs_q[cdb_tag] <= cdb_data;
                rdy_q[cdb_tag]  <= 1'b1;
            end
            if (dispatch_valid && (dest_tag != '0)) begin
                rdy_q[dest_tag] <= 1'b0;  // fresh destination waits for its result
            end
        end
    end

endmodule

// File: src/reservation_station.sv
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module reservation_station import ooo_pkg::*; #(
    parameter int DEPTH = `OOO_ROB_DEPTH
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      dispatch_en,
    input  alu_op_t   dispatch_op,
    input  xdata_t    dispatch_imm,
    input  phys_tag_t src1_tag,
    input  phys_tag_t src2_tag,
    input  phys_tag_t dest_tag,
    input  xdata_t    src1_data,
    input  xdata_t    src2_data,
    input  logic      src1_ready,
    input  logic      src2_ready,
    input  rob_idx_t  dispatch_rob_idx,
    input  logic      cdb_valid,
    input  phys_tag_t cdb_tag,
    input  xdata_t    cdb_data,
    input  logic      grant,
    output logic      req,
    output alu_op_t   req_op,
    output xdata_t    req_a,
    output xdata_t    req_b,
    output phys_tag_t req_tag,
    output rob_idx_t  req_rob_idx
);
    localparam int SW = $clog2(DEPTH);

    logic [DEPTH-1:0] vld_q;
    logic [DEPTH-1:0] a_rdy_q;
    logic [DEPTH-1:0] b_rdy_q;
    logic [DEPTH-1:0] older_q [DEPTH];  // bit j set when entry j came first
    logic [DEPTH-1:0] rdy;
    logic [DEPTH-1:0] a_hit;
    logic [DEPTH-1:0] b_hit;
    logic [SW-1:0]    sel;
    logic [SW-1:0]    slot;
    alu_op_t          op_q [DEPTH];
    xdata_t           a_q [DEPTH];
    xdata_t           b_q [DEPTH];
    phys_tag_t        a_tag_q [DEPTH];
    phys_tag_t        b_tag_q [DEPTH];
    phys_tag_t        dest_q [DEPTH];
    rob_idx_t         rob_q [DEPTH];

    always_comb begin
        rdy = vld_q & a_rdy_q & b_rdy_q;
        for (int i = 0; i < DEPTH; i++) begin
            a_hit[i] = cdb_valid && !a_rdy_q[i] && (a_tag_q[i] == cdb_tag);
            b_hit[i] = cdb_valid && !b_rdy_q[i] && (b_tag_q[i] == cdb_tag);
        end
        // oldest ready entry has no ready entry ahead of it
        req = 1'b0;
        sel = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (rdy[i] && !(|(older_q[i] & rdy))) begin
                req = 1'b1;
                sel = SW'(i);
            end
        end
        slot = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!vld_q[i]) begin
                slot = SW'(i);  // lowest free entry
            end
        end
    end

    assign req_op      = op_q[sel];
    assign req_a       = a_q[sel];
    assign req_b       = b_q[sel];
    assign req_tag     = dest_q[sel];
    assign req_rob_idx = rob_q[sel];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q   <= '0;
            a_rdy_q <= '0;
            b_rdy_q <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                older_q[i] <= '0;
            end
        end else begin
            a_rdy_q <= a_rdy_q | a_hit;
            b_rdy_q <= b_rdy_q | b_hit;
            if (grant) begin
                vld_q[sel] <= 1'b0;
            end
            if (dispatch_en) begin
                for (int i = 0; i < DEPTH; i++) begin
                    older_q[i][slot] <= 1'b0;
                end
                older_q[slot] <= vld_q;
                vld_q[slot]   <= 1'b1;
                a_rdy_q[slot] <= src1_ready;
                b_rdy_q[slot] <= src2_ready || (dispatch_op == op_addi);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (a_hit[i]) begin
                a_q[i] <= cdb_data;
            end
            if (b_hit[i]) begin
                b_q[i] <= cdb_data;
            end
        end
        if (dispatch_en) begin
            op_q[slot]    <= dispatch_op;
            a_q[slot]     <= src1_data;
            b_q[slot]     <= (dispatch_op == op_addi) ? dispatch_imm : src2_data;
            a_tag_q[slot] <= src1_tag;
            b_tag_q[slot] <= src2_tag;
            dest_q[slot]  <= dest_tag;
            rob_q[slot]   <= dispatch_rob_idx;
        end
    end

endmodule

// File: src/execute_cluster.sv
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module execute_cluster import ooo_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      alu_req,
    input  alu_op_t   alu_op,
    input  xdata_t    alu_a,
    input  xdata_t    alu_b,
    input  phys_tag_t alu_tag,
    input  rob_idx_t  alu_rob_idx,
    input  logic      mul_req,
    input  xdata_t    mul_a,
    input  xdata_t    mul_b,
    input  phys_tag_t mul_tag,
    input  rob_idx_t  mul_rob_idx,
    output logic      alu_grant,
    output logic      mul_grant,
    output logic      cdb_valid,
    output phys_tag_t cdb_tag,
    output rob_idx_t  cdb_rob_idx,
    output xdata_t    cdb_data
);
    localparam int CW = $clog2(`OOO_MUL_CYCLES);
    localparam logic [CW-1:0] MUL_LAST = CW'(`OOO_MUL_CYCLES - 1);

    mul_state_t    mul_state;
    logic [CW-1:0] mul_cnt;
    logic          mul_on_bus;
    xdata_t        mcand_q;
    xdata_t        mplier_q;
    xdata_t        acc_q;
    phys_tag_t     mul_tag_q;
    rob_idx_t      mul_rob_q;
    xdata_t        alu_res;
    logic          alu_out_valid;
    xdata_t        alu_data_q;
    phys_tag_t     alu_tag_q;
    rob_idx_t      alu_rob_q;

    assign mul_on_bus = (mul_state == mul_done);  // multiplier wins the bus

    // a held alu result must leave before the next grant
    assign alu_grant = alu_req && (!alu_out_valid || !mul_on_bus);
    assign mul_grant = mul_req && (mul_state == mul_idle);

    assign cdb_valid   = mul_on_bus || alu_out_valid;
    assign cdb_tag     = mul_on_bus ? mul_tag_q : alu_tag_q;
    assign cdb_rob_idx = mul_on_bus ? mul_rob_q : alu_rob_q;
    assign cdb_data    = mul_on_bus ? acc_q : alu_data_q;

    always_comb begin
        unique case (alu_op)
            op_sub:  alu_res = alu_a - alu_b;
            op_and:  alu_res = alu_a & alu_b;
            op_or:   alu_res = alu_a | alu_b;
            op_xor:  alu_res = alu_a ^ alu_b;
            default: alu_res = alu_a + alu_b;  // add, addi
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_out_valid <= 1'b0;
        end else if (alu_grant) begin
            alu_out_valid <= 1'b1;
        end else if (!mul_on_bus) begin
            alu_out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_grant) begin
            alu_data_q <= alu_res;
            alu_tag_q  <= alu_tag;
            alu_rob_q  <= alu_rob_idx;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_state <= mul_idle;
            mul_cnt   <= '0;
        end else begin
            unique case (mul_state)
                mul_idle: begin
                    if (mul_grant) begin
                        mul_state <= mul_busy;
                        mul_cnt   <= CW'(1);  // first step taken at grant
                    end
                end
                mul_busy: begin
                    mul_cnt <= mul_cnt + 1'b1;
                    if (mul_cnt == MUL_LAST) begin
                        mul_state <= mul_done;
                    end
                end
                default: mul_state <= mul_idle;  // done lasts one bus cycle
            endcase
        end
    end

    // shift-add keeps only the low half of the product
    always_ff @(posedge clk) begin
        if (mul_grant) begin
            mcand_q   <= mul_a << 1;
            mplier_q  <= mul_b >> 1;
            acc_q     <= mul_b[0] ? mul_a : '0;
            mul_tag_q <= mul_tag;
            mul_rob_q <= mul_rob_idx;
        end else if (mul_state == mul_busy) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

endmodule

// File: src/reorder_buffer.sv
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module reorder_buffer import ooo_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      dispatch_valid,
    input  arch_reg_t dispatch_rd,
    input  phys_tag_t old_tag,
    input  logic      cdb_valid,
    input  rob_idx_t  cdb_rob_idx,
    input  xdata_t    cdb_data,
    output rob_idx_t  alloc_idx,
    output logic      commit_valid,
    output logic      commit_we,
    output arch_reg_t commit_rd,
    output xdata_t    commit_data,
    output logic      free_valid,
    output phys_tag_t free_tag,
    output logic      credit_return
);
    rob_idx_t                 head_q;
    rob_idx_t                 tail_q;
    logic [`OOO_ROB_DEPTH-1:0] busy_q;
    logic [`OOO_ROB_DEPTH-1:0] done_q;
    arch_reg_t                rd_q [`OOO_ROB_DEPTH];
    phys_tag_t                old_q [`OOO_ROB_DEPTH];
    xdata_t                   res_q [`OOO_ROB_DEPTH];

    assign alloc_idx = tail_q;

    assign commit_valid  = busy_q[head_q] && done_q[head_q];
    assign commit_rd     = rd_q[head_q];
    assign commit_data   = res_q[head_q];
    assign commit_we     = commit_valid && (rd_q[head_q] != '0);
    assign free_valid    = commit_we;  // x0 never took a tag
    assign free_tag      = old_q[head_q];
    assign credit_return = commit_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q <= '0;
            tail_q <= '0;
            busy_q <= '0;
            done_q <= '0;
        end else begin
            if (commit_valid) begin
                busy_q[head_q] <= 1'b0;
                head_q         <= head_q + 1'b1;
            end
            if (cdb_valid) begin
                done_q[cdb_rob_idx] <= 1'b1;
            end
            if (dispatch_valid) begin
                busy_q[tail_q] <= 1'b1;
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_valid) begin
            rd_q[tail_q]  <= dispatch_rd;
            old_q[tail_q] <= old_tag;
        end
        if (cdb_valid) begin
            res_q[cdb_rob_idx] <= cdb_data;
        end
    end

endmodule

// File: src/ooo_core_top.sv
`timescale 1ns/1ps

module ooo_core_top import ooo_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      issue_valid,
    input  alu_op_t   issue_op,
    input  arch_reg_t issue_rd,
    input  arch_reg_t issue_rs1,
    input  arch_reg_t issue_rs2,
    input  imm_t      issue_imm,
    output logic      commit_valid,
    output arch_reg_t commit_rd,
    output logic      commit_we,
    output xdata_t    commit_data,
    output logic      credit_return
);
    // dispatch bundle
    phys_tag_t src1_tag;
    phys_tag_t src2_tag;
    phys_tag_t dest_tag;
    phys_tag_t old_tag;
    logic      dispatch_alu;
    logic      dispatch_mul;
    alu_op_t   dispatch_op;
    xdata_t    dispatch_imm;
    arch_reg_t dispatch_rd;
    xdata_t    src1_data;
    xdata_t    src2_data;
    logic      src1_ready;
    logic      src2_ready;
    rob_idx_t  alloc_idx;

    logic      free_valid;
    phys_tag_t free_tag;

    // common data bus
    logic      cdb_valid;
    phys_tag_t cdb_tag;
    rob_idx_t  cdb_rob_idx;
    xdata_t    cdb_data;

    logic      alu_req;
    logic      alu_grant;
    alu_op_t   alu_op;
    xdata_t    alu_a;
    xdata_t    alu_b;
    phys_tag_t alu_tag;
    rob_idx_t  alu_rob_idx;
    logic      mul_req;
    logic      mul_grant;
    xdata_t    mul_a;
    xdata_t    mul_b;
    phys_tag_t mul_tag;
    rob_idx_t  mul_rob_idx;

    rename_unit rename_i (
        .clk(clk), .rst_n(rst_n),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_rd(issue_rd),
        .issue_rs1(issue_rs1), .issue_rs2(issue_rs2), .issue_imm(issue_imm),
        .free_valid(free_valid), .free_tag(free_tag),
        .src1_tag(src1_tag), .src2_tag(src2_tag),
        .dispatch_alu(dispatch_alu), .dispatch_mul(dispatch_mul),
        .dispatch_op(dispatch_op), .dispatch_imm(dispatch_imm),
        .dest_tag(dest_tag), .old_tag(old_tag), .dispatch_rd(dispatch_rd)
    );

    phys_regfile prf_i (
        .clk(clk), .rst_n(rst_n),
        .src1_tag(src1_tag), .src2_tag(src2_tag), .dest_tag(dest_tag),
        .dispatch_valid(issue_valid),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
        .src1_data(src1_data), .src2_data(src2_data),
        .src1_ready(src1_ready), .src2_ready(src2_ready)
    );

    reservation_station alu_rs_i (
        .clk(clk), .rst_n(rst_n),
        .dispatch_en(dispatch_alu), .dispatch_op(dispatch_op), .dispatch_imm(dispatch_imm),
        .src1_tag(src1_tag), .src2_tag(src2_tag), .dest_tag(dest_tag),
        .src1_data(src1_data), .src2_data(src2_data),
        .src1_ready(src1_ready), .src2_ready(src2_ready), .dispatch_rob_idx(alloc_idx),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
        .grant(alu_grant), .req(alu_req), .req_op(alu_op),
        .req_a(alu_a), .req_b(alu_b), .req_tag(alu_tag), .req_rob_idx(alu_rob_idx)
    );

    reservation_station mul_rs_i (
        .clk(clk), .rst_n(rst_n),
        .dispatch_en(dispatch_mul), .dispatch_op(dispatch_op), .dispatch_imm(dispatch_imm),
        .src1_tag(src1_tag), .src2_tag(src2_tag), .dest_tag(dest_tag),
        .src1_data(src1_data), .src2_data(src2_data),
        .src1_ready(src1_ready), .src2_ready(src2_ready), .dispatch_rob_idx(alloc_idx),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
        .grant(mul_grant), .req(mul_req), .req_op(),
        .req_a(mul_a), .req_b(mul_b), .req_tag(mul_tag), .req_rob_idx(mul_rob_idx)
    );

    execute_cluster exec_i (
        .clk(clk), .rst_n(rst_n),
        .alu_req(alu_req), .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
        .alu_tag(alu_tag), .alu_rob_idx(alu_rob_idx),
        .mul_req(mul_req), .mul_a(mul_a), .mul_b(mul_b),
        .mul_tag(mul_tag), .mul_rob_idx(mul_rob_idx),
        .alu_grant(alu_grant), .mul_grant(mul_grant),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag),
        .cdb_rob_idx(cdb_rob_idx), .cdb_data(cdb_data)
    );

    reorder_buffer rob_i (
        .clk(clk), .rst_n(rst_n),
        .dispatch_valid(issue_valid), .dispatch_rd(dispatch_rd), .old_tag(old_tag),
        .cdb_valid(cdb_valid), .cdb_rob_idx(cdb_rob_idx), .cdb_data(cdb_data),
        .alloc_idx(alloc_idx),
        .commit_valid(commit_valid), .commit_we(commit_we),
        .commit_rd(commit_rd), .commit_data(commit_data),
        .free_valid(free_valid), .free_tag(free_tag),
        .credit_return(credit_return)
    );

endmodule

// File: tb/ooo_core_properties.sv
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module ooo_core_properties import ooo_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input logic      issue_valid,
    input logic      credit_return,
    input logic      cdb_valid,
    input rob_idx_t  cdb_rob_idx,
    input logic      commit_we,
    input arch_reg_t commit_rd
);
    int credits_q;   // sender side view of the credits
    int fail_count;

    initial fail_count = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits_q <= `OOO_ROB_DEPTH;
        end else begin
            credits_q <= credits_q - int'(issue_valid) + int'(credit_return);
        end
    end

    issue_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> credits_q > 0)
        else begin
            $error("issue seen with no credit left");
            fail_count++;
        end

    // one result per rob slot and never twice in a row
    cdb_no_repeat: assert property (@(posedge clk) disable iff (!rst_n)
        cdb_valid ##1 cdb_valid |-> cdb_rob_idx != $past(cdb_rob_idx))
        else begin
            $error("same rob index on the data bus two cycles running");
            fail_count++;
        end

    no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        commit_we |-> commit_rd != '0)
        else begin
            $error("commit write enable high for x0");
            fail_count++;
        end

endmodule

// File: tb/ooo_core_tb.sv
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module ooo_core_tb import ooo_pkg::*; ();
    localparam int CREDIT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT  = 3000;
    localparam int RANDOM_OPS     = 300;
    localparam int SEED           = 32'hf2b4;

    logic      clk;
    logic      rst_n;
    logic      issue_valid;
    alu_op_t   issue_op;
    arch_reg_t issue_rd;
    arch_reg_t issue_rs1;
    arch_reg_t issue_rs2;
    imm_t      issue_imm;
    logic      commit_valid;
    arch_reg_t commit_rd;
    logic      commit_we;
    xdata_t    commit_data;
    logic      credit_return;

    xdata_t    ref_regs [`OOO_ARCH_REGS];  // architectural state in program order
    arch_reg_t exp_rd_q [$];
    xdata_t    exp_data_q [$];
    int        n_issued;
    int        n_commits;
    int        n_returned;
    int        errors;
    int        tests_run;
    int        tests_failed;
    logic      hung;

    ooo_core_top dut_i (
        .clk(clk), .rst_n(rst_n),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_rd(issue_rd),
        .issue_rs1(issue_rs1), .issue_rs2(issue_rs2), .issue_imm(issue_imm),
        .commit_valid(commit_valid), .commit_rd(commit_rd),
        .commit_we(commit_we), .commit_data(commit_data),
        .credit_return(credit_return)
    );

    bind ooo_core_top ooo_core_properties props_i (
        .clk(clk), .rst_n(rst_n),
        .issue_valid(issue_valid), .credit_return(credit_return),
        .cdb_valid(cdb_valid), .cdb_rob_idx(cdb_rob_idx),
        .commit_we(commit_we), .commit_rd(commit_rd)
    );

    always #2 clk = ~clk;

    function automatic xdata_t ref_result(alu_op_t op, xdata_t a, xdata_t b, imm_t imm);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_addi: return a + {{(`OOO_XLEN - 12){imm[11]}}, imm};
            default: return a * b;  // low word of the product
        endcase
    endfunction

    function automatic int credits_left();
        return `OOO_ROB_DEPTH - n_issued + n_returned;
    endfunction

    // drives on the next falling edge once a credit is free
    task automatic issue_one(input alu_op_t op, input int rd, input int rs1,
                             input int rs2, input int imm);
        int     waited;
        xdata_t result;
        waited = 0;
        @(negedge clk);
        while (credits_left() == 0 && waited < CREDIT_TIMEOUT && !hung) begin
            issue_valid = 1'b0;
            @(negedge clk);
            waited++;
        end
        if (credits_left() == 0 || hung) begin
            issue_valid = 1'b0;
            if (!hung) begin
                $display("timeout: no credit came back within %0d cycles", CREDIT_TIMEOUT);
            end
            hung = 1'b1;
        end else begin
            issue_valid = 1'b1;
            issue_op    = op;
            issue_rd    = arch_reg_t'(rd);
            issue_rs1   = arch_reg_t'(rs1);
            issue_rs2   = arch_reg_t'(rs2);
            issue_imm   = imm_t'(imm);
            n_issued++;
            result = ref_result(op, ref_regs[issue_rs1], ref_regs[issue_rs2], issue_imm);
            exp_rd_q.push_back(issue_rd);
            exp_data_q.push_back(result);
            if (issue_rd != '0) begin
                ref_regs[issue_rd] = result;  // x0 stays zero
            end
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        @(negedge clk);
        issue_valid = 1'b0;
        while (n_commits != n_issued && cycles < DRAIN_TIMEOUT && !hung) begin
            @(negedge clk);
            cycles++;
        end
        if (n_commits != n_issued && !hung) begin
            $display("timeout: %0d instructions still in flight after %0d cycles",
                     n_issued - n_commits, DRAIN_TIMEOUT);
            hung = 1'b1;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        logic bad;
        bad = (errors != errs_before) || hung;
        tests_run++;
        if (bad) begin
            tests_failed++;
        end
        $display("test %0d %-24s %s", num, name, bad ? "failed" : "ok");
    endtask

    // compare process samples outputs before the edge updates them
    always @(posedge clk) begin
        arch_reg_t rd_exp;
        xdata_t    data_exp;
        if (rst_n) begin
            if (credit_return) begin
                n_returned++;
            end
            if (commit_valid) begin
                n_commits++;
                assert (exp_rd_q.size() > 0) else begin
                    errors++;
                    $display("commit at %0t with no instruction outstanding", $time);
                end
                if (exp_rd_q.size() > 0) begin
                    rd_exp   = exp_rd_q.pop_front();
                    data_exp = exp_data_q.pop_front();
                    assert (commit_rd == rd_exp && commit_we == (rd_exp != '0)) else begin
                        errors++;
                        $display("[FAIL] %0t commit rd %0d we %0b, expected rd %0d we %0b",
                                 $time, commit_rd, commit_we, rd_exp, rd_exp != '0);
                    end
                    if (rd_exp != '0) begin
                        assert (commit_data == data_exp) else begin
                            errors++;
                            $display("[FAIL] %0t commit x%0d data %h, expected %h",
                                     $time, rd_exp, commit_data, data_exp);
                        end
                    end
                end
            end
        end
    end

    initial begin
        int errs;
        int prop_fails;
        clk = 1'b0;
        rst_n = 1'b0;
        issue_valid = 1'b0;
        issue_op = op_add;
        issue_rd = '0;
        issue_rs1 = '0;
        issue_rs2 = '0;
        issue_imm = '0;
        n_issued = 0;
        n_commits = 0;
        n_returned = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        hung = 1'b0;
        for (int i = 0; i < `OOO_ARCH_REGS; i++) begin
            ref_regs[i] = '0;
        end
        void'($urandom(SEED));
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        errs = errors;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            assert (!commit_valid && !credit_return) else begin
                errors++;
                $display("[FAIL] %0t commit or credit activity with nothing issued", $time);
            end
        end
        issue_one(op_addi, 5, 0, 0, 12'h9ab);  // negative immediate
        wait_drain();
        report_test(1, "idle then first addi", errs);

        errs = errors;
        issue_one(op_addi, 1, 0, 0, 7);
        issue_one(op_add, 2, 1, 1, 0);
        issue_one(op_sub, 3, 2, 1, 0);
        issue_one(op_xor, 4, 3, 2, 0);
        issue_one(op_or, 5, 4, 1, 0);
        issue_one(op_and, 6, 5, 4, 0);
        issue_one(op_addi, 7, 6, 0, 12'hffd);
        issue_one(op_sub, 8, 0, 7, 0);
        wait_drain();
        report_test(2, "dependent alu chain", errs);

        errs = errors;
        issue_one(op_mul, 9, 7, 3, 0);
        issue_one(op_addi, 10, 0, 0, 12'h123);
        issue_one(op_xor, 11, 1, 2, 0);
        issue_one(op_or, 12, 4, 5, 0);
        issue_one(op_add, 13, 10, 11, 0);
        wait_drain();
        report_test(3, "mul before alu ops", errs);

        errs = errors;
        issue_one(op_addi, 0, 1, 0, 5);
        issue_one(op_add, 0, 2, 3, 0);
        issue_one(op_mul, 0, 4, 5, 0);
        issue_one(op_add, 14, 0, 1, 0);
        issue_one(op_or, 15, 0, 0, 0);
        wait_drain();
        report_test(4, "writes to x0", errs);

        errs = errors;
        issue_one(op_mul, 16, 2, 3, 0);
        for (int i = 0; i < `OOO_ROB_DEPTH - 1; i++) begin
            issue_one(op_addi, 17 + i, i + 1, 0, i);
        end
        assert (credits_left() == 0) else begin
            errors++;
            $display("[FAIL] %0t %0d credits left with the rob full, expected 0",
                     $time, credits_left());
        end
        wait_drain();
        assert (n_returned == n_commits && n_commits == n_issued) else begin
            errors++;
            $display("[FAIL] %0t issued %0d commits %0d credit returns %0d",
                     $time, n_issued, n_commits, n_returned);
        end
        report_test(5, "credit flow", errs);

        errs = errors;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            issue_one(alu_op_t'($urandom_range(6, 0)), int'($urandom_range(31, 0)),
                      int'($urandom_range(31, 0)), int'($urandom_range(31, 0)),
                      int'($urandom_range(4095, 0)));
        end
        wait_drain();
        report_test(6, "random stream", errs);

        repeat (2) @(negedge clk);
        prop_fails = dut_i.props_i.fail_count;
        $display("tests %0d, failed %0d, commits %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, n_commits, errors, prop_fails);
        if (errors == 0 && prop_fails == 0 && tests_failed == 0 && !hung) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+src
src/ooo_pkg.sv
src/rename_unit.sv
src/phys_regfile.sv
src/reservation_station.sv
src/execute_cluster.sv
src/reorder_buffer.sv
src/ooo_core_top.sv
tb/ooo_core_properties.sv
tb/ooo_core_tb.sv

// File: Bender.yml
package:
  name: ooo_core

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/ooo_pkg.sv
      - src/rename_unit.sv
      - src/phys_regfile.sv
      - src/reservation_station.sv
      - src/execute_cluster.sv
      - src/reorder_buffer.sv
      - src/ooo_core_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/ooo_core_properties.sv
      - tb/ooo_core_tb.sv
